// ==== project.f ====
src/stream_pkg.sv
src/buffer_pkg.sv
src/word_packer.sv
src/line_buffer.sv
src/gather_top.sv
testbench/gather_tb.sv

// ==== Makefile ====
TOP := gather_tb

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing --assert --top-module gather_top \
		src/stream_pkg.sv src/buffer_pkg.sv src/word_packer.sv \
		src/line_buffer.sv src/gather_top.sv
	verilator --lint-only --timing --assert --top-module $(TOP) -f project.f

sim:
	verilator --binary --timing --assert --top-module $(TOP) -f project.f
	./obj_dir/V$(TOP)

clean:
	rm -rf obj_dir

// ==== testbench/gather_tb.sv ====
// self-checking testbench for gather_top, random sample, clear and read traffic checked against a model
`timescale 1ns/100ps

module gather_tb
    import stream_pkg::*;
    import buffer_pkg::*;
();

    localparam int clk_period         = 10;
    localparam int reset_cycles       = 4;
    localparam int num_samples        = 3000;
    localparam int valid_pct          = 70;   // share of cycles carrying a sample
    localparam int read_pct           = 30;
    localparam int clear_rate         = 300;  // roughly one free-running clear in this many cycles
    localparam int clear_on_word_rate = 60;   // extra clears aimed at word_valid cycles
    localparam int drain_cycles       = 4;
    localparam int watchdog_cycles    = num_samples * 20;

    logic    clk;
    logic    reset;
    logic    sample_valid;
    sample_t sample;
    logic    clear;
    rd_req_t rd_req;
    word_t   rd_data;
    logic    rd_valid;
    level_t  level;
    logic    full;

    integer seed = 32'hc10523a7;

    // reference model of the packer and the buffer
    sample_t     group_q[$];         // samples of the group being gathered
    buffer_mem_t model_mem;
    addr_t       model_ptr;
    level_t      model_level;
    logic        pending_valid;      // word_valid expected in the current cycle
    word_t       pending_word;
    word_t       expected_reads[$];
    logic        exp_rd_valid;

    // inputs applied in the current cycle, taken by the DUT at the next edge
    logic    cur_valid;
    sample_t cur_sample;
    logic    cur_clear;
    rd_req_t cur_rd;

    int accepted;
    int full_cycles;
    int clear_drops;
    int full_drops;
    int reads_checked;

    gather_top dut
    (
        .clk          (clk),
        .reset        (reset),
        .sample_valid (sample_valid),
        .sample       (sample),
        .clear        (clear),
        .rd_req       (rd_req),
        .rd_data      (rd_data),
        .rd_valid     (rd_valid),
        .level        (level),
        .full         (full)
    );

    initial
    begin
        clk = 1'b0;
        forever #(clk_period / 2) clk = ~clk;
    end

    task automatic report_failure(input string msg);
        $display("%s", msg);
        $display("Some tests failed");
        $fatal(1);
    endtask

    // one rising edge of the design, using the inputs that were applied during the cycle
    task automatic advance_model();
        word_t w;
        int    i;
        if (cur_rd.valid)
        begin
            expected_reads.push_back(model_mem[cur_rd.addr]);  // array as it stood before this edge
        end
        exp_rd_valid = cur_rd.valid;
        if (cur_clear)
        begin
            if (pending_valid)
            begin
                clear_drops++;  // clear wins over the word of the same cycle
            end
            model_ptr   = '0;
            model_level = '0;
        end
        else if (pending_valid)
        begin
            if (model_level == level_t'(buffer_depth))
            begin
                full_drops++;
            end
            else
            begin
                model_mem[model_ptr] = pending_word;
                model_ptr            = model_ptr + addr_t'(1);
                model_level          = model_level + level_t'(1);
            end
        end
        pending_valid = 1'b0;
        if (cur_valid)
        begin
            group_q.push_back(cur_sample);
            accepted++;
            if (group_q.size() == lane_count)
            begin
                // the first sample of a group belongs in lane 0
                for (i = 0; i < lane_count; i++)
                begin
                    w.lane[i] = group_q[i];
                end
                pending_word  = w;
                pending_valid = 1'b1;
                group_q.delete();
            end
        end
    endtask

    task automatic drive_inputs(input logic active);
        logic [31:0] r;
        r          = $random(seed);
        cur_valid  = active && (r % 100 < valid_pct);
        r          = $random(seed);
        cur_sample = r[sample_width-1:0];
        r          = $random(seed);
        cur_clear  = active && (r % clear_rate == 0);
        r          = $random(seed);
        if (active && pending_valid && (r % clear_on_word_rate == 0))
        begin
            cur_clear = 1'b1;  // lands on a word_valid cycle
        end
        cur_rd.valid = 1'b0;
        cur_rd.addr  = '0;
        r            = $random(seed);
        if (active && model_level != 0 && (r % 100 < read_pct))
        begin
            r            = $random(seed);
            cur_rd.valid = 1'b1;
            cur_rd.addr  = addr_t'(r % 32'(model_level));  // only words written since the last clear
        end
        sample_valid <= cur_valid;
        sample       <= cur_sample;
        clear        <= cur_clear;
        rd_req       <= cur_rd;
    endtask

    task automatic check_outputs();
        word_t exp_word;
        logic  exp_full;
        exp_full = (model_level == level_t'(buffer_depth));
        assert (level == model_level)
        else report_failure($sformatf("MISMATCH level: got %h expected %h", level, model_level));
        assert (full == exp_full)
        else report_failure($sformatf("MISMATCH full: got %h expected %h", full, exp_full));
        assert (rd_valid == exp_rd_valid)
        else report_failure($sformatf("MISMATCH rd_valid: got %h expected %h",
                                      rd_valid, exp_rd_valid));
        if (rd_valid)
        begin
            exp_word = expected_reads.pop_front();
            assert (rd_data == exp_word)
            else report_failure($sformatf("MISMATCH rd_data: got %h expected %h",
                                          rd_data, exp_word));
            reads_checked++;
        end
        if (full)
        begin
            full_cycles++;
        end
    endtask

    initial
    begin
        repeat (watchdog_cycles) @(posedge clk);
        report_failure("watchdog expired before all samples were sent and checked");
    end

    initial
    begin
        reset         = 1'b1;
        sample_valid  = 1'b0;
        sample        = '0;
        clear         = 1'b0;
        rd_req        = '0;
        cur_valid     = 1'b0;
        cur_sample    = '0;
        cur_clear     = 1'b0;
        cur_rd        = '0;
        model_ptr     = '0;
        model_level   = '0;
        pending_valid = 1'b0;
        pending_word  = '0;
        exp_rd_valid  = 1'b0;
        accepted      = 0;
        full_cycles   = 0;
        clear_drops   = 0;
        full_drops    = 0;
        reads_checked = 0;

        repeat (reset_cycles) @(posedge clk);
        reset <= 1'b0;
        @(negedge clk);
        assert (!rd_valid && !full && level == '0)
        else report_failure("outputs not idle after reset");

        while (accepted < num_samples)
        begin
            @(posedge clk);
            advance_model();
            drive_inputs(1'b1);
            @(negedge clk);
            check_outputs();
        end

        // let the last read responses come back
        repeat (drain_cycles)
        begin
            @(posedge clk);
            advance_model();
            drive_inputs(1'b0);
            @(negedge clk);
            check_outputs();
        end

        if (full_cycles > 0 && clear_drops > 0 && full_drops > 0 && reads_checked > 0)
        begin
            $display("All tests passed");
            $finish;
        end
        else
        begin
            report_failure("stimulus never reached full, a drop when full and a clear on a word");
        end
    end

endmodule

// ==== src/gather_top.sv ====
// top level of the sample gatherer, packing the sample stream into words and buffering them for readback
`timescale 1ns/100ps

module gather_top
    import stream_pkg::*;
    import buffer_pkg::*;
(
    input  logic    clk,
    input  logic    reset,
    input  logic    sample_valid,  // accepted whenever high, no back-pressure
    input  sample_t sample,
    input  logic    clear,
    input  rd_req_t rd_req,
    output word_t   rd_data,
    output logic    rd_valid,
    output level_t  level,
    output logic    full
);

    // completed word and its one-cycle pulse from the packer into the buffer
    word_t word;
    logic  word_valid;

    word_packer packer
    (
        .clk          (clk),
        .reset        (reset),
        .sample_valid (sample_valid),
        .sample       (sample),
        .word         (word),
        .word_valid   (word_valid)
    );

    // words land in the buffer at the edge that ends their valid cycle
    line_buffer buffer
    (
        .clk        (clk),
        .reset      (reset),
        .clear      (clear),
        .word       (word),
        .word_valid (word_valid),
        .rd_req     (rd_req),
        .rd_data    (rd_data),
        .rd_valid   (rd_valid),
        .level      (level),
        .full       (full)
    );

endmodule

// ==== src/line_buffer.sv ====
// on-chip line buffer that stores packed words in arrival order and serves registered reads by address
`timescale 1ns/100ps

module line_buffer
    import stream_pkg::*;
    import buffer_pkg::*;
(
    input  logic    clk,
    input  logic    reset,
    input  logic    clear,
    input  word_t   word,
    input  logic    word_valid,
    input  rd_req_t rd_req,
    output word_t   rd_data,
    output logic    rd_valid,
    output level_t  level,
    output logic    full
);

    buffer_mem_t mem;       // word storage, no reset
    addr_t       wr_ptr_q;  // next address to write
    level_t      level_q;   // words stored since the last clear
    logic        write_en;

    // full follows the stored level directly
    assign full = (level_q == level_t'(buffer_depth));

    assign level = level_q;

    // clear takes priority over a word arriving in the same cycle, a full buffer drops words
    assign write_en = word_valid && !full && !clear;

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            wr_ptr_q <= '0;
            level_q  <= '0;
        end
        else if (clear)
        begin
            wr_ptr_q <= '0;
            level_q  <= '0;
        end
        else if (write_en)
        begin
            wr_ptr_q <= wr_ptr_q + addr_t'(1);
            level_q  <= level_q + level_t'(1);
        end
    end

    always_ff @(posedge clk)
    begin
        if (write_en)
        begin
            mem[wr_ptr_q] <= word;
        end
    end

    // the read strobe is registered along with the data so both appear one cycle later
    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            rd_valid <= 1'b0;
        end
        else
        begin
            rd_valid <= rd_req.valid;
        end
    end

    always_ff @(posedge clk)
    begin
        if (rd_req.valid)
        begin
            rd_data <= mem[rd_req.addr];  // data is held between reads
        end
    end

    level_in_range: assert property (
        @(posedge clk) disable iff (reset)
        level_q <= level_t'(buffer_depth)
    )
    else $error("fill level beyond buffer_depth");

    // a request yields exactly one response cycle and nothing appears without one
    read_latency_one: assert property (
        @(posedge clk) disable iff (reset)
        1'b1 |=> (rd_valid == $past(rd_req.valid))
    )
    else $error("rd_valid does not follow rd_req.valid by one cycle");

endmodule

// ==== src/word_packer.sv ====
// serial-in parallel-out packer that turns a strobe of narrow samples into wide words with a valid pulse
`timescale 1ns/100ps

module word_packer
    import stream_pkg::*;
(
    input  logic    clk,
    input  logic    reset,
    input  logic    sample_valid,
    input  sample_t sample,
    output word_t   word,
    output logic    word_valid
);

    word_t                       shift_q;       // lanes gathered so far
    logic [lane_count_width-1:0] lane_count_q;  // accepted samples of the current group
    logic                        count_full;
    logic                        count_full_d;

    // the group is complete once the counter has reached the lane count
    assign count_full = (lane_count_q == lane_count_width'(lane_count));

    // only the first cycle of a full counter is reported, so each group gives one pulse
    assign word_valid = count_full && !count_full_d;

    assign word = shift_q;

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            count_full_d <= 1'b0;
        end
        else
        begin
            count_full_d <= count_full;
        end
    end

    // a word_valid cycle closes the group; a sample arriving in it starts the next one
    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            lane_count_q <= '0;
        end
        else if (word_valid)
        begin
            lane_count_q <= sample_valid ? lane_count_width'(1) : '0;
        end
        else if (sample_valid)
        begin
            lane_count_q <= lane_count_q + lane_count_width'(1);
        end
    end

    // new samples enter the top lane and older ones move down towards lane 0
    always_ff @(posedge clk)
    begin
        if (sample_valid)
        begin
            shift_q.lane <= {sample, shift_q.lane[lane_count-1:1]};
        end
    end

    // the pulse must drop again before the next group can complete
    word_valid_single_cycle: assert property (
        @(posedge clk) disable iff (reset)
        word_valid |=> !word_valid
    )
    else $error("word_valid held high for two cycles");

    lane_count_in_range: assert property (
        @(posedge clk) disable iff (reset)
        lane_count_q <= lane_count_width'(lane_count)
    )
    else $error("lane counter beyond lane_count");

endmodule

// ==== src/buffer_pkg.sv ====
// line buffer geometry, address types and the read request port shared by buffer, top and testbench
package buffer_pkg;

    import stream_pkg::*;

    // number of packed words held on chip
    localparam int buffer_depth = 16;

    localparam int addr_width = $clog2(buffer_depth);

    // a word address inside the buffer
    typedef logic [addr_width-1:0] addr_t;

    // fill level runs from 0 up to buffer_depth inclusive, hence one extra bit
    typedef logic [addr_width:0] level_t;

    // read strobe and its address travel together
    typedef struct packed
    {
        logic  valid;  // one-cycle request strobe
        addr_t addr;   // word to return on the next cycle
    } rd_req_t;

    // storage array of the line buffer
    typedef word_t buffer_mem_t [buffer_depth];

endpackage

// ==== src/stream_pkg.sv ====
// sample and packed word definitions shared by the packer, the line buffer and the testbench
package stream_pkg;

    // one incoming sample from the memory read port
    localparam int sample_width = 16;

    // samples gathered into one wide word, a whole multiple of the sample width
    localparam int lane_count = 4;

    // the lane counter has to reach lane_count itself, so it needs one bit more than the index
    localparam int lane_count_width = $clog2(lane_count) + 1;

    typedef logic [sample_width-1:0] sample_t;

    // lane 0 sits in the low bits and holds the oldest sample of a group
    typedef struct packed
    {
        sample_t [lane_count-1:0] lane;
    } word_t;

endpackage
